// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_lsab_dram_top
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

check: run
	@grep -qF '$(PASS_MSG)' $(LOG) && echo "check: pass message found in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
lsab_pkg.sv
dram_pkg.sv
lsab_sections.sv
mvblck_todram.sv
dram_bank_port.sv
move_ctrl.sv
lsab_dram_top.sv
tb_lsab_dram_top.sv

// ==== dram_bank_port.sv ====
`timescale 1ns/1ps

module dram_bank_port #(
	parameter int BANK_ROWS = 64
) (
	input  logic                                  CLK,
	input  logic                                  RST,
	input  logic [1:0]                            request_access,
	input  logic [dram_pkg::ADDR_W-1:0]           coll_address,
	input  logic [dram_pkg::LANES-1:0]            we_array,
	input  logic [dram_pkg::ROW_W-1:0]            data,
	input  logic                                  dbg_bank,
	input  logic [$clog2(BANK_ROWS)-1:0]          dbg_row,
	output logic [dram_pkg::ROW_W-1:0]            dbg_data
);

	localparam int ROW_IDX_W = $clog2(BANK_ROWS);
	localparam int LANE_W    = dram_pkg::ROW_W / dram_pkg::LANES;

	logic [dram_pkg::ROW_W-1:0] rows [2][BANK_ROWS];
	logic [ROW_IDX_W-1:0] row_idx;

	// word address to row, dropping the word-in-row bit
	assign row_idx  = coll_address[ROW_IDX_W:1];
	assign dbg_data = rows[dbg_bank][dbg_row];

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			for (int b = 0; b < 2; b++)
			begin
				for (int r = 0; r < BANK_ROWS; r++)
					rows[b][r] <= '0;
			end
		end
		else
		begin
			for (int l = 0; l < dram_pkg::LANES; l++)
			begin
				if (we_array[l])
				begin
					if (request_access == dram_pkg::BANK0_SEL)
						rows[0][row_idx][l*LANE_W +: LANE_W] <= data[l*LANE_W +: LANE_W];
					else if (request_access == dram_pkg::BANK1_SEL)
						rows[1][row_idx][l*LANE_W +: LANE_W] <= data[l*LANE_W +: LANE_W];
				end
			end
		end
	end

	// the mover always addresses the even word of a row
	a_even_addr: assert property (@(posedge CLK) disable iff (!RST)
		(request_access != 2'b00) |-> !coll_address[0]);

endmodule

// ==== dram_pkg.sv ====
package dram_pkg;

	// word address, bit 0 picks the word inside a row
	localparam int ADDR_W = 12;

	// one row holds two buffer words
	localparam int ROW_W = 32;

	// byte lanes per row
	localparam int LANES = 4;

	// one-hot bank request codes, zero means no request
	localparam logic [1:0] BANK0_SEL = 2'b01;
	localparam logic [1:0] BANK1_SEL = 2'b10;

endpackage

// ==== lsab_dram_top.sv ====
`timescale 1ns/1ps

module lsab_dram_top #(
	parameter int SECTION_DEPTH = 16,
	parameter int BANK_ROWS     = 64
) (
	input  logic                                  CLK,
	input  logic                                  RST,
	input  logic                                  wr_en,
	input  lsab_pkg::section_t                    wr_section,
	input  logic [lsab_pkg::WORD_W-1:0]           wr_data,
	input  logic                                  wr_mark,
	input  logic                                  issue,
	input  lsab_pkg::section_t                    cmd_section,
	input  logic [dram_pkg::ADDR_W-1:0]           cmd_start,
	input  logic [lsab_pkg::COUNT_W-1:0]          cmd_count,
	input  logic [1:0]                            cmd_bank,
	input  logic                                  dbg_bank,
	input  logic [$clog2(BANK_ROWS)-1:0]          dbg_row,
	output logic                                  cmd_full,
	output logic                                  move_done,
	output logic [lsab_pkg::COUNT_W-1:0]          status_count,
	output logic                                  status_abrupt,
	output logic                                  status_irq,
	output logic                                  status_valid,
	output logic [dram_pkg::ROW_W-1:0]            dbg_data
);

	// buffer to mover
	logic [lsab_pkg::WORD_W-1:0] head_data;
	logic [lsab_pkg::NUM_SECTIONS-1:0] sec_stop;
	logic [lsab_pkg::NUM_SECTIONS-1:0] sec_int;
	logic [lsab_pkg::NUM_SECTIONS-1:0] sec_valid;
	logic lsab_read;
	lsab_pkg::section_t lsab_section;

	// control to mover and back
	logic mv_start;
	lsab_pkg::section_t mv_section;
	logic [dram_pkg::ADDR_W-1:0] mv_start_address;
	logic [lsab_pkg::COUNT_W-1:0] mv_count_req;
	logic [1:0] mv_dram_sel;
	logic mv_working;
	logic mv_done;
	logic [lsab_pkg::COUNT_W-1:0] mv_count_sent;
	logic mv_abrupt;
	logic mv_irq;
	logic mv_valid;

	// mover to DRAM port
	logic [1:0] mcu_request_access;
	logic [dram_pkg::ADDR_W-1:0] mcu_coll_address;
	logic [dram_pkg::LANES-1:0] mcu_we_array;
	logic [dram_pkg::ROW_W-1:0] mcu_data;

	lsab_sections #(.SECTION_DEPTH(SECTION_DEPTH)) u_lsab (
		.CLK(CLK), .RST(RST),
		.wr_en(wr_en), .wr_section(wr_section), .wr_data(wr_data), .wr_mark(wr_mark),
		.rd_en(lsab_read), .rd_section(lsab_section),
		.head_data(head_data), .stop(sec_stop), .int_flag(sec_int), .valid(sec_valid)
	);

	move_ctrl u_ctrl (
		.CLK(CLK), .RST(RST),
		.issue(issue), .cmd_section(cmd_section), .cmd_start(cmd_start),
		.cmd_count(cmd_count), .cmd_bank(cmd_bank),
		.mv_working(mv_working), .mv_done(mv_done), .mv_count_sent(mv_count_sent),
		.mv_abrupt(mv_abrupt), .mv_irq(mv_irq), .mv_valid(mv_valid),
		.cmd_full(cmd_full), .mv_start(mv_start), .mv_section(mv_section),
		.mv_start_address(mv_start_address), .mv_count_req(mv_count_req),
		.mv_dram_sel(mv_dram_sel), .move_done(move_done), .status_count(status_count),
		.status_abrupt(status_abrupt), .status_irq(status_irq), .status_valid(status_valid)
	);

	mvblck_todram u_mover (
		.CLK(CLK), .RST(RST),
		.start(mv_start), .section(mv_section), .start_address(mv_start_address),
		.count_req(mv_count_req), .dram_sel(mv_dram_sel),
		.head_data(head_data), .stop(sec_stop), .int_flag(sec_int), .valid(sec_valid),
		.lsab_read(lsab_read), .lsab_section(lsab_section),
		.working(mv_working), .done(mv_done), .count_sent(mv_count_sent),
		.abrupt_stop(mv_abrupt), .irq_out(mv_irq), .valid_out(mv_valid),
		.mcu_coll_address(mcu_coll_address), .mcu_we_array(mcu_we_array),
		.mcu_request_access(mcu_request_access), .mcu_data(mcu_data)
	);

	dram_bank_port #(.BANK_ROWS(BANK_ROWS)) u_dram (
		.CLK(CLK), .RST(RST),
		.request_access(mcu_request_access), .coll_address(mcu_coll_address),
		.we_array(mcu_we_array), .data(mcu_data),
		.dbg_bank(dbg_bank), .dbg_row(dbg_row), .dbg_data(dbg_data)
	);

endmodule

// ==== lsab_pkg.sv ====
package lsab_pkg;

	// one buffer word
	localparam int WORD_W = 16;

	// buffer sections, each an independent FIFO
	localparam int NUM_SECTIONS = 4;

	// word count carried by a move command
	localparam int COUNT_W = 6;

	// section index, wide enough for NUM_SECTIONS
	typedef logic [1:0] section_t;

endpackage

// ==== lsab_sections.sv ====
`timescale 1ns/1ps

module lsab_sections #(
	parameter int SECTION_DEPTH = 16
) (
	input  logic                                  CLK,
	input  logic                                  RST,
	input  logic                                  wr_en,
	input  lsab_pkg::section_t                    wr_section,
	input  logic [lsab_pkg::WORD_W-1:0]           wr_data,
	input  logic                                  wr_mark,
	input  logic                                  rd_en,
	input  lsab_pkg::section_t                    rd_section,
	output logic [lsab_pkg::WORD_W-1:0]           head_data,
	output logic [lsab_pkg::NUM_SECTIONS-1:0]     stop,
	output logic [lsab_pkg::NUM_SECTIONS-1:0]     int_flag,
	output logic [lsab_pkg::NUM_SECTIONS-1:0]     valid
);

	localparam int PTR_W = $clog2(SECTION_DEPTH);
	localparam int OCC_W = $clog2(SECTION_DEPTH + 1);

	// head word of every section, picked by rd_section below
	logic [lsab_pkg::WORD_W-1:0] heads [lsab_pkg::NUM_SECTIONS];

	assign head_data = heads[rd_section];

	for (genvar s = 0; s < lsab_pkg::NUM_SECTIONS; s++)
	begin : g_sec
		logic [lsab_pkg::WORD_W-1:0] mem [SECTION_DEPTH];
		logic [PTR_W-1:0] wp;
		logic [PTR_W-1:0] rp;
		logic [OCC_W-1:0] occ;
		logic push;
		logic pop;

		// a push into a full section is dropped
		assign push = wr_en && (wr_section == lsab_pkg::section_t'(s)) && (occ != SECTION_DEPTH);
		assign pop  = rd_en && (rd_section == lsab_pkg::section_t'(s)) && (occ != 0);

		assign heads[s]    = mem[rp];
		assign stop[s]     = (occ == 0);
		assign valid[s]    = (occ != 0);

		always_ff @(posedge CLK)
		begin
			if (push)
				mem[wp] <= wr_data;
		end

		always_ff @(posedge CLK)
		begin
			if (!RST)
			begin
				wp          <= '0;
				rp          <= '0;
				occ         <= '0;
				int_flag[s] <= 1'b0;
			end
			else
			begin
				if (push)
					wp <= (wp == PTR_W'(SECTION_DEPTH - 1)) ? '0 : wp + 1'b1;
				if (pop)
					rp <= (rp == PTR_W'(SECTION_DEPTH - 1)) ? '0 : rp + 1'b1;
				case ({push, pop})
					2'b10:   occ <= occ + 1'b1;
					2'b01:   occ <= occ - 1'b1;
					default: occ <= occ;
				endcase
				// mark sticks until the section drains
				if (push && wr_mark)
					int_flag[s] <= 1'b1;
				else if (pop && !push && occ == 1)
					int_flag[s] <= 1'b0;
			end
		end

		a_occ_bound: assert property (@(posedge CLK) disable iff (!RST)
			occ <= SECTION_DEPTH);
	end

endmodule

// ==== move_ctrl.sv ====
`timescale 1ns/1ps

module move_ctrl (
	input  logic                                  CLK,
	input  logic                                  RST,
	input  logic                                  issue,
	input  lsab_pkg::section_t                    cmd_section,
	input  logic [dram_pkg::ADDR_W-1:0]           cmd_start,
	input  logic [lsab_pkg::COUNT_W-1:0]          cmd_count,
	input  logic [1:0]                            cmd_bank,
	input  logic                                  mv_working,
	input  logic                                  mv_done,
	input  logic [lsab_pkg::COUNT_W-1:0]          mv_count_sent,
	input  logic                                  mv_abrupt,
	input  logic                                  mv_irq,
	input  logic                                  mv_valid,
	output logic                                  cmd_full,
	output logic                                  mv_start,
	output lsab_pkg::section_t                    mv_section,
	output logic [dram_pkg::ADDR_W-1:0]           mv_start_address,
	output logic [lsab_pkg::COUNT_W-1:0]          mv_count_req,
	output logic [1:0]                            mv_dram_sel,
	output logic                                  move_done,
	output logic [lsab_pkg::COUNT_W-1:0]          status_count,
	output logic                                  status_abrupt,
	output logic                                  status_irq,
	output logic                                  status_valid
);

	lsab_pkg::section_t hold_section;
	logic [dram_pkg::ADDR_W-1:0] hold_start;
	logic [lsab_pkg::COUNT_W-1:0] hold_count;
	logic [1:0] hold_bank;
	logic busy_q;
	logic launch;

	// busy_q covers the cycles before the mover's delayed working level rises
	assign launch = cmd_full && !busy_q && !mv_working && !mv_done;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			cmd_full      <= 1'b0;
			busy_q        <= 1'b0;
			mv_start      <= 1'b0;
			move_done     <= 1'b0;
			status_count  <= '0;
			status_abrupt <= 1'b0;
			status_irq    <= 1'b0;
			status_valid  <= 1'b0;
		end
		else
		begin
			mv_start  <= launch;
			move_done <= mv_done;
			// an issue while full is dropped
			if (launch)
				cmd_full <= 1'b0;
			else if (issue)
				cmd_full <= 1'b1;
			if (launch)
				busy_q <= 1'b1;
			else if (mv_done)
				busy_q <= 1'b0;
			if (mv_done)
			begin
				status_count  <= mv_count_sent;
				status_abrupt <= mv_abrupt;
				status_irq    <= mv_irq;
				status_valid  <= mv_valid;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (issue && !cmd_full)
		begin
			hold_section <= cmd_section;
			hold_start   <= cmd_start;
			hold_count   <= cmd_count;
			hold_bank    <= cmd_bank;
		end
		if (launch)
		begin
			mv_section       <= hold_section;
			mv_start_address <= hold_start;
			mv_count_req     <= hold_count;
			mv_dram_sel      <= hold_bank;
		end
	end

endmodule

// ==== mvblck_todram.sv ====
`timescale 1ns/1ps

module mvblck_todram (
	input  logic                                  CLK,
	input  logic                                  RST,
	input  logic                                  start,
	input  lsab_pkg::section_t                    section,
	input  logic [dram_pkg::ADDR_W-1:0]           start_address,
	input  logic [lsab_pkg::COUNT_W-1:0]          count_req,
	input  logic [1:0]                            dram_sel,
	input  logic [lsab_pkg::WORD_W-1:0]           head_data,
	input  logic [lsab_pkg::NUM_SECTIONS-1:0]     stop,
	input  logic [lsab_pkg::NUM_SECTIONS-1:0]     int_flag,
	input  logic [lsab_pkg::NUM_SECTIONS-1:0]     valid,
	output logic                                  lsab_read,
	output lsab_pkg::section_t                    lsab_section,
	output logic                                  working,
	output logic                                  done,
	output logic [lsab_pkg::COUNT_W-1:0]          count_sent,
	output logic                                  abrupt_stop,
	output logic                                  irq_out,
	output logic                                  valid_out,
	output logic [dram_pkg::ADDR_W-1:0]           mcu_coll_address,
	output logic [dram_pkg::LANES-1:0]            mcu_we_array,
	output logic [1:0]                            mcu_request_access,
	output logic [dram_pkg::ROW_W-1:0]            mcu_data
);

	logic am_working;
	logic [lsab_pkg::COUNT_W-1:0] len_left;
	logic [lsab_pkg::COUNT_W-1:0] count_q;
	logic [dram_pkg::ADDR_W-1:0] track_addr;
	logic [1:0] sel_q;
	logic [lsab_pkg::WORD_W-1:0] even_q;
	logic even_v;
	logic read_more;
	logic stop_n;
	logic finish;
	logic stop_sel;
	logic irq_sel;
	logic valid_sel;

	// flags of the section being drained
	always_comb
	begin
		stop_sel  = stop[lsab_section];
		irq_sel   = int_flag[lsab_section];
		valid_sel = valid[lsab_section];
	end

	assign read_more = (len_left != 0);
	// stop_n high means a word leaves the section this cycle
	assign stop_n    = am_working && read_more && !stop_sel;
	assign finish    = !stop_n || (len_left == 1);

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			am_working         <= 1'b0;
			working            <= 1'b0;
			lsab_read          <= 1'b0;
			lsab_section       <= '0;
			done               <= 1'b0;
			mcu_request_access <= 2'b00;
			even_v             <= 1'b0;
			len_left           <= '0;
		end
		else
		begin
			done               <= 1'b0;
			mcu_request_access <= 2'b00;
			if (!am_working)
			begin
				lsab_section <= section;
				len_left     <= count_req;
				am_working   <= start;
				lsab_read    <= start && (count_req != 0);
				even_v       <= 1'b0;
			end
			else
			begin
				if (stop_n)
				begin
					len_left <= len_left - 1'b1;
					if (track_addr[0])
					begin
						// odd word completes the row
						mcu_request_access <= sel_q;
						even_v             <= 1'b0;
					end
					else if (finish)
					begin
						// last word is even, upper lanes only
						mcu_request_access <= sel_q;
						even_v             <= 1'b0;
					end
					else
						even_v <= 1'b1;
				end
				else if (even_v)
				begin
					mcu_request_access <= sel_q;
					even_v             <= 1'b0;
				end
				if (finish)
				begin
					am_working <= 1'b0;
					lsab_read  <= 1'b0;
					done       <= 1'b1;
				end
			end
			// one cycle behind so the launch logic sees a settled level
			working <= am_working;
		end
	end

	// payload registers
	always_ff @(posedge CLK)
	begin
		if (!am_working)
		begin
			track_addr <= start_address;
			count_q    <= count_req;
			sel_q      <= dram_sel;
		end
		else
		begin
			if (stop_n)
			begin
				track_addr <= track_addr + 1'b1;
				mcu_coll_address <= {track_addr[dram_pkg::ADDR_W-1:1], 1'b0};
				if (track_addr[0])
				begin
					mcu_we_array <= {even_v, even_v, 2'b11};
					mcu_data     <= {even_q, head_data};
				end
				else
				begin
					mcu_we_array <= 4'b1100;
					mcu_data     <= {head_data, {lsab_pkg::WORD_W{1'b0}}};
					even_q       <= head_data;
				end
			end
			else
			begin
				mcu_coll_address <= {track_addr[dram_pkg::ADDR_W-1:1], 1'b0};
				mcu_we_array     <= 4'b1100;
				mcu_data         <= {even_q, {lsab_pkg::WORD_W{1'b0}}};
			end
			if (finish)
			begin
				count_sent  <= count_q - len_left + {{(lsab_pkg::COUNT_W-1){1'b0}}, stop_n};
				abrupt_stop <= !stop_n && read_more;
				irq_out     <= irq_sel;
				valid_out   <= valid_sel;
			end
		end
	end

	a_one_bank: assert property (@(posedge CLK) disable iff (!RST)
		mcu_request_access != (dram_pkg::BANK0_SEL | dram_pkg::BANK1_SEL));

endmodule

// ==== tb_lsab_dram_top.sv ====
`timescale 1ns/1ps

module tb_lsab_dram_top;

	localparam int SECTION_DEPTH = 16;
	localparam int BANK_ROWS     = 64;
	localparam int ROW_IDX_W     = $clog2(BANK_ROWS);
	localparam int TIMEOUT       = 200;

	logic CLK;
	logic RST;
	logic wr_en;
	lsab_pkg::section_t wr_section;
	logic [lsab_pkg::WORD_W-1:0] wr_data;
	logic wr_mark;
	logic issue;
	lsab_pkg::section_t cmd_section;
	logic [dram_pkg::ADDR_W-1:0] cmd_start;
	logic [lsab_pkg::COUNT_W-1:0] cmd_count;
	logic [1:0] cmd_bank;
	logic dbg_bank;
	logic [ROW_IDX_W-1:0] dbg_row;
	logic cmd_full;
	logic move_done;
	logic [lsab_pkg::COUNT_W-1:0] status_count;
	logic status_abrupt;
	logic status_irq;
	logic status_valid;
	logic [dram_pkg::ROW_W-1:0] dbg_data;

	// reference model of the sections and of both banks
	logic [15:0] sec_mem [4][64];
	int sec_rd [4];
	int sec_wr [4];
	logic sec_flag [4];
	logic [31:0] exp_rows [2][BANK_ROWS];
	logic [31:0] rng_state;

	lsab_dram_top #(
		.SECTION_DEPTH(SECTION_DEPTH),
		.BANK_ROWS(BANK_ROWS)
	) u_dut (
		.CLK(CLK), .RST(RST),
		.wr_en(wr_en), .wr_section(wr_section), .wr_data(wr_data), .wr_mark(wr_mark),
		.issue(issue), .cmd_section(cmd_section), .cmd_start(cmd_start),
		.cmd_count(cmd_count), .cmd_bank(cmd_bank),
		.dbg_bank(dbg_bank), .dbg_row(dbg_row),
		.cmd_full(cmd_full), .move_done(move_done), .status_count(status_count),
		.status_abrupt(status_abrupt), .status_irq(status_irq),
		.status_valid(status_valid), .dbg_data(dbg_data)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#4 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
				$time, name, got, exp));
	endtask

	task automatic push_word(input int s, input logic [15:0] d, input logic m);
		wr_en      = 1'b1;
		wr_section = lsab_pkg::section_t'(s);
		wr_data    = d;
		wr_mark    = m;
		next_cycle();
		wr_en   = 1'b0;
		wr_mark = 1'b0;
		sec_mem[s][sec_wr[s]] = d;
		sec_wr[s] = sec_wr[s] + 1;
		if (m)
			sec_flag[s] = 1'b1;
	endtask

	// mark_at of -1 pushes no marked word
	task automatic fill_section(input int s, input int n, input int mark_at);
		for (int i = 0; i < n; i++)
		begin
			rng_state = xorshift32(rng_state);
			push_word(s, rng_state[15:0], i == mark_at);
		end
	endtask

	// even address goes to lanes 3:2, odd address to lanes 1:0
	task automatic model_move(input int s, input int start, input int count, input int bank,
			output int exp_cnt, output logic exp_abrupt, output logic exp_irq,
			output logic exp_valid);
		int avail;
		int row;
		logic [dram_pkg::ADDR_W-1:0] addr;
		logic [15:0] w;
		avail      = sec_wr[s] - sec_rd[s];
		exp_cnt    = (count > avail) ? avail : count;
		exp_abrupt = (count > avail);
		exp_valid  = !exp_abrupt;
		// an early stop means the section drained, clearing its mark
		exp_irq    = sec_flag[s] && !exp_abrupt;
		for (int i = 0; i < exp_cnt; i++)
		begin
			addr = dram_pkg::ADDR_W'(start + i);
			row  = int'(addr[ROW_IDX_W:1]);
			w    = sec_mem[s][sec_rd[s]];
			sec_rd[s] = sec_rd[s] + 1;
			if (addr[0])
				exp_rows[bank][row][15:0] = w;
			else
				exp_rows[bank][row][31:16] = w;
		end
		if (sec_rd[s] == sec_wr[s])
			sec_flag[s] = 1'b0;
	endtask

	task automatic issue_cmd(input int s, input int start, input int count, input int bank);
		issue       = 1'b1;
		cmd_section = lsab_pkg::section_t'(s);
		cmd_start   = dram_pkg::ADDR_W'(start);
		cmd_count   = lsab_pkg::COUNT_W'(count);
		cmd_bank    = (bank == 1) ? dram_pkg::BANK1_SEL : dram_pkg::BANK0_SEL;
		next_cycle();
		issue = 1'b0;
	endtask

	task automatic wait_move_done();
		int n;
		n = 0;
		while (move_done !== 1'b1)
		begin
			if (n == TIMEOUT)
				stop_on_error("timeout: move_done did not rise after a move command");
			else
			begin
				next_cycle();
				n++;
			end
		end
	endtask

	task automatic wait_cmd_taken();
		int n;
		n = 0;
		while (cmd_full !== 1'b0)
		begin
			if (n == TIMEOUT)
				stop_on_error("timeout: the held command was never launched");
			else
			begin
				next_cycle();
				n++;
			end
		end
	endtask

	task automatic check_status(input int cnt, input logic abrupt, input logic irq,
			input logic valid);
		check_value("status_count", 32'(status_count), 32'(cnt));
		check_value("status_abrupt", 32'(status_abrupt), 32'(abrupt));
		check_value("status_irq", 32'(status_irq), 32'(irq));
		check_value("status_valid", 32'(status_valid), 32'(valid));
	endtask

	task automatic run_move(input int s, input int start, input int count, input int bank);
		int cnt;
		logic abrupt;
		logic irq;
		logic valid;
		model_move(s, start, count, bank, cnt, abrupt, irq, valid);
		issue_cmd(s, start, count, bank);
		wait_move_done();
		check_status(cnt, abrupt, irq, valid);
		next_cycle();
	endtask

	// reads every row of both banks through the debug port
	task automatic verify_banks();
		for (int b = 0; b < 2; b++)
		begin
			for (int r = 0; r < BANK_ROWS; r++)
			begin
				dbg_bank = b[0];
				dbg_row  = ROW_IDX_W'(r);
				#1;
				check_value($sformatf("dbg_data bank%0d row%0d", b, r), dbg_data,
					exp_rows[b][r]);
				next_cycle();
			end
		end
	endtask

	task automatic test_even_block();
		fill_section(0, 8, -1);
		run_move(0, 8, 8, 0);
		verify_banks();
	endtask

	// partial rows overlap the rows written by the even block
	task automatic test_odd_edges();
		fill_section(1, 9, -1);
		run_move(1, 9, 6, 0);
		run_move(1, 31, 3, 0);
		verify_banks();
	endtask

	// an odd word count leaves an even word to flush when the section runs dry
	task automatic test_early_stop();
		fill_section(2, 5, -1);
		run_move(2, 0, 10, 1);
		verify_banks();
	endtask

	task automatic test_irq_and_empty();
		fill_section(3, 5, 1);
		run_move(3, 50, 3, 1);
		check_value("status_irq", 32'(status_irq), 32'd1);
		// section 0 was drained by the even block
		run_move(0, 60, 4, 0);
		verify_banks();
	endtask

	task automatic test_queued_cmd();
		int cnt_a;
		int cnt_b;
		logic abrupt_a;
		logic abrupt_b;
		logic irq_a;
		logic irq_b;
		logic valid_a;
		logic valid_b;
		fill_section(1, 6, -1);
		fill_section(2, 4, -1);
		model_move(1, 40, 6, 0, cnt_a, abrupt_a, irq_a, valid_a);
		model_move(2, 20, 4, 1, cnt_b, abrupt_b, irq_b, valid_b);
		issue_cmd(1, 40, 6, 0);
		wait_cmd_taken();
		issue_cmd(2, 20, 4, 1);
		// second command waits in the holding register
		check_value("cmd_full", 32'(cmd_full), 32'd1);
		check_value("move_done", 32'(move_done), 32'd0);
		wait_move_done();
		check_status(cnt_a, abrupt_a, irq_a, valid_a);
		next_cycle();
		wait_move_done();
		check_status(cnt_b, abrupt_b, irq_b, valid_b);
		next_cycle();
		verify_banks();
	endtask

	initial
	begin
		RST         = 1'b0;
		wr_en       = 1'b0;
		wr_section  = '0;
		wr_data     = '0;
		wr_mark     = 1'b0;
		issue       = 1'b0;
		cmd_section = '0;
		cmd_start   = '0;
		cmd_count   = '0;
		cmd_bank    = 2'b00;
		dbg_bank    = 1'b0;
		dbg_row     = '0;
		rng_state   = 32'd40;
		for (int s = 0; s < 4; s++)
		begin
			sec_rd[s]   = 0;
			sec_wr[s]   = 0;
			sec_flag[s] = 1'b0;
		end
		for (int b = 0; b < 2; b++)
		begin
			for (int r = 0; r < BANK_ROWS; r++)
				exp_rows[b][r] = '0;
		end
		repeat (4) @(posedge CLK);
		#1;
		RST = 1'b1;
		next_cycle();
		check_value("cmd_full", 32'(cmd_full), 32'd0);
		check_value("move_done", 32'(move_done), 32'd0);

		test_even_block();
		test_odd_edges();
		test_early_stop();
		test_irq_and_empty();
		test_queued_cmd();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
